// File: verilog.f
src/stDataPkg.sv
src/spiDataClient.sv
src/ramHost.sv
src/dmaStatus.sv
src/acsiOutFifo.sv
src/stDataTop.sv
verification/stData_asserts.sv
verification/stDataTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= stDataTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= -Wno-fatal
SIMARGS   ?= +verilator+error+limit+1000
PASS      := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; echo "$$out"; \
		echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf $(OBJDIR)

// File: verification/stDataTb.sv
// clock, reset, spi transfer tasks, stimulus for the seven commands, error count
`timescale 1ns/1ps
`default_nettype none

module stDataTb;

	localparam int halfSck   = 16; // clk_8 periods per sck half period
	localparam int idleLimit = 64; // clocks allowed for spiSel to go idle

	logic clk_8 = 1'b0;
	logic ss;
	logic sdi;
	logic sck;
	logic spiSel;
	logic sdo;
	stDataPkg::wordT ctrlOut;
	logic statusWe;
	stDataPkg::dmaIdxT statusIdx;
	stDataPkg::byteT statusData;
	logic acsiPush;
	stDataPkg::acsiWordT acsiPushData;
	logic acsiFull;

	int seed     = 25277;
	int errors   = 0;
	int timeouts = 0;
	stDataPkg::wordT words [4];        // ram test data
	stDataPkg::byteT status [4];       // status bytes 0..3
	stDataPkg::acsiWordT acsiWords [3];
	stDataPkg::wordT ctrlWord;
	stDataPkg::addrT baseAddr;
	stDataPkg::byteT rx;
	stDataPkg::byteT rxHi;

	stDataTop UUT (
		.clk_8        (clk_8),
		.ss           (ss),
		.sdi          (sdi),
		.sck          (sck),
		.spiSel       (spiSel),
		.sdo          (sdo),
		.ctrlOut      (ctrlOut),
		.statusWe     (statusWe),
		.statusIdx    (statusIdx),
		.statusData   (statusData),
		.acsiPush     (acsiPush),
		.acsiPushData (acsiPushData),
		.acsiFull     (acsiFull)
	);

	always #4 clk_8 = ~clk_8; // 8 ns period

	// inputs change 1 ns after the rising edge
	task automatic waitClocks(input int n);
		repeat (n) @(posedge clk_8);
		#1;
	endtask

	task automatic checkValue(input logic [15:0] got, input logic [15:0] exp, input string what);
		assert (got === exp) else begin
			$display("CHECK FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic startTransfer();
		int n;
		n = 0;
		while (!spiSel && (n < idleLimit)) begin // select must be idle first
			waitClocks(1);
			n++;
		end
		if (!spiSel) begin
			$display("timeout at time %0t: spi select did not go idle", $time);
			timeouts++;
		end
		spiSel = 1'b0;
		waitClocks(halfSck);
	endtask

	task automatic endTransfer();
		waitClocks(halfSck);
		spiSel = 1'b1;
		waitClocks(2 * halfSck); // let clk_8 side settle
	endtask

	// msb first with sdo read just before the rising sck edge
	task automatic shiftByte(input stDataPkg::byteT tx, output stDataPkg::byteT rxb);
		for (int i = 7; i >= 0; i--) begin
			sdi = tx[i];
			waitClocks(halfSck);
			rxb[i] = sdo;
			sck = 1'b1;
			waitClocks(halfSck);
			sck = 1'b0;
		end
	endtask

	task automatic setAddress(input stDataPkg::addrT addr);
		logic [23:0] a;
		stDataPkg::byteT dummy;
		a = {1'b0, addr}; // 24 bits shifted so the top one falls out
		startTransfer();
		shiftByte(stDataPkg::cmdSetAddr, dummy);
		shiftByte(a[23:16], dummy);
		shiftByte(a[15:8], dummy);
		shiftByte(a[7:0], dummy);
		endTransfer();
	endtask

	task automatic loadStatus(input stDataPkg::dmaIdxT idx, input stDataPkg::byteT data);
		statusIdx  = idx;
		statusData = data;
		statusWe   = 1'b1;
		waitClocks(1);
		statusWe   = 1'b0;
	endtask

	task automatic pushAcsi(input stDataPkg::acsiWordT w);
		acsiPushData = w;
		acsiPush     = 1'b1;
		waitClocks(1);
		acsiPush     = 1'b0;
	endtask

	// bytes 0..3 in index order with byte 0 zero once acknowledged
	task automatic readStatusBytes(input logic busyCleared);
		stDataPkg::byteT b;
		stDataPkg::byteT exp;
		startTransfer();
		shiftByte(stDataPkg::cmdReadDma, b);
		for (int k = 0; k < 4; k++) begin
			shiftByte(8'h00, b);
			exp = ((k == 0) && busyCleared) ? 8'h00 : status[k];
			checkValue(16'(b), 16'(exp), $sformatf("status byte %0d", k));
		end
		endTransfer();
	endtask

	initial begin
		ss           = 1'b1;
		sdi          = 1'b0;
		sck          = 1'b0;
		spiSel       = 1'b1; // idle
		statusWe     = 1'b0;
		statusIdx    = '0;
		statusData   = '0;
		acsiPush     = 1'b0;
		acsiPushData = '0;
		waitClocks(4);
		ss = 1'b0;
		waitClocks(8);

		// control register
		ctrlWord = stDataPkg::wordT'($random(seed));
		startTransfer();
		shiftByte(stDataPkg::cmdSetCtrl, rx);
		shiftByte(ctrlWord[15:8], rx);
		shiftByte(ctrlWord[7:0], rx);
		endTransfer();
		checkValue(ctrlOut, ctrlWord, "ctrlOut after command 4");

		// four words written then read back from the same address
		baseAddr = stDataPkg::addrT'($random(seed));
		setAddress(baseAddr);
		startTransfer();
		shiftByte(stDataPkg::cmdWriteRam, rx);
		for (int k = 0; k < 4; k++) begin
			words[k] = stDataPkg::wordT'($random(seed));
			shiftByte(words[k][15:8], rx);
			shiftByte(words[k][7:0], rx);
		end
		endTransfer();
		setAddress(baseAddr);
		startTransfer();
		shiftByte(stDataPkg::cmdReadRam, rx);
		for (int k = 0; k < 4; k++) begin
			shiftByte(8'h00, rxHi);
			shiftByte(8'h00, rx);
			checkValue({rxHi, rx}, words[k], $sformatf("ram word %0d", k));
		end
		endTransfer();

		// status file read then acknowledge
		for (int k = 0; k < 4; k++)
			status[k] = stDataPkg::byteT'($random(seed));
		status[0] = status[0] | 8'h80; // busy byte nonzero so the clear shows
		for (int k = 0; k < 4; k++)
			loadStatus(stDataPkg::dmaIdxT'(k), status[k]);
		readStatusBytes(1'b0);
		startTransfer();
		shiftByte(stDataPkg::cmdDmaAck, rx);
		shiftByte(8'h00, rx);
		endTransfer();
		readStatusBytes(1'b1);

		// acsi fifo drain with flag byte then data byte per entry
		for (int k = 0; k < 3; k++) begin
			acsiWords[k] = stDataPkg::acsiWordT'($random(seed));
			pushAcsi(acsiWords[k]);
		end
		startTransfer();
		shiftByte(stDataPkg::cmdReadAcsi, rx);
		for (int k = 0; k < 3; k++) begin
			shiftByte(8'h00, rxHi);
			shiftByte(8'h00, rx);
			checkValue(16'(rxHi), 16'({5'd0, acsiWords[k][9:8], 1'b1}),
				$sformatf("acsi flag %0d", k));
			checkValue(16'(rx), 16'(acsiWords[k][7:0]), $sformatf("acsi data %0d", k));
		end
		shiftByte(8'h00, rxHi);
		checkValue(16'(rxHi[0]), 16'(1'b0), "acsi flag after drain");
		endTransfer();

		// fill the empty fifo up to the full flag
		for (int k = 0; k < 7; k++)
			pushAcsi(stDataPkg::acsiWordT'($random(seed)));
		checkValue(16'(acsiFull), 16'(1'b0), "acsiFull with seven entries");
		pushAcsi(stDataPkg::acsiWordT'($random(seed)));
		checkValue(16'(acsiFull), 16'(1'b1), "acsiFull with eight entries");

		$display("errors: %0d checks, %0d timeouts, %0d assertions",
			errors, timeouts, UUT.checks.failCount);
		if ((errors + timeouts + UUT.checks.failCount) == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/stData_asserts.sv
// ram handshake, reset state and dma ack assertions bound into stDataTop
`timescale 1ns/1ps
`default_nettype none

module stData_asserts (
	input wire clk_8,
	input wire ss,
	input wire spiSel,
	input wire dmaAck,
	input wire stDataPkg::ramReqS ramReq,
	input wire ack
);

	int failCount = 0;
	logic isAccess;

	assign isAccess = (ramReq.state == stDataPkg::ramWrite)
		|| (ramReq.state == stDataPkg::ramRead);

	// access codes last a single cycle
	oneCycleCode: assert property (@(posedge clk_8) disable iff (ss) isAccess |=> !isAccess)
		else begin
			$error("ram access code held for two cycles");
			failCount++;
		end

	ackAfterAccess: assert property (@(posedge clk_8) disable iff (ss) isAccess |=> ack)
		else begin
			$error("no ack one cycle after a ram access");
			failCount++;
		end

	initDuringReset: assert property (@(posedge clk_8) ss |-> (ramReq.state == stDataPkg::ramInit))
		else begin
			$error("ram state not init during reset");
			failCount++;
		end

	ackNeedsSelect: assert property (@(posedge clk_8) disable iff (ss) spiSel |-> !dmaAck)
		else begin
			$error("dma ack high while spi select idle");
			failCount++;
		end

endmodule

bind stDataTop stData_asserts checks (
	.clk_8  (clk_8),
	.ss     (ss),
	.spiSel (spiSel),
	.dmaAck (dmaAck),
	.ramReq (ramReq),
	.ack    (ack)
);

`default_nettype wire

// File: src/stDataTop.sv
// top level with spi data client, ram host, dma status file and acsi fifo
`timescale 1ns/1ps
`default_nettype none

module stDataTop (
	input  wire clk_8,
	input  wire ss,
	// spi pins
	input  wire sdi,
	input  wire sck,
	input  wire spiSel,
	output logic sdo,
	output stDataPkg::wordT ctrlOut,
	// status load port
	input  wire statusWe,
	input  wire stDataPkg::dmaIdxT statusIdx,
	input  wire stDataPkg::byteT statusData,
	// acsi push port
	input  wire acsiPush,
	input  wire stDataPkg::acsiWordT acsiPushData,
	output logic acsiFull
);

	stDataPkg::busCycleT busCycle;
	stDataPkg::ramReqS ramReq;
	stDataPkg::wordT ramData;
	logic ack;
	stDataPkg::dmaIdxT dmaIdx;
	stDataPkg::byteT dmaData;
	logic dmaAck;
	stDataPkg::acsiOutS acsiOut;
	logic acsiOutStrobe;

	spiDataClient client (
		.clk_8         (clk_8),
		.ss            (ss),
		.busCycle      (busCycle),
		.sdi           (sdi),
		.sck           (sck),
		.spiSel        (spiSel),
		.sdo           (sdo),
		.ctrlOut       (ctrlOut),
		.dmaIdx        (dmaIdx),
		.dmaData       (dmaData),
		.dmaAck        (dmaAck),
		.acsiOut       (acsiOut),
		.acsiOutStrobe (acsiOutStrobe),
		.ramReq        (ramReq),
		.ramData       (ramData),
		.ack           (ack)
	);

	ramHost ram (
		.clk_8    (clk_8),
		.ss       (ss),
		.busCycle (busCycle),
		.ramReq   (ramReq),
		.ramData  (ramData),
		.ack      (ack)
	);

	dmaStatus status (
		.clk_8      (clk_8),
		.ss         (ss),
		.statusWe   (statusWe),
		.statusIdx  (statusIdx),
		.statusData (statusData),
		.dmaIdx     (dmaIdx),
		.dmaData    (dmaData),
		.dmaAck     (dmaAck)
	);

	acsiOutFifo acsiFifo (
		.clk_8         (clk_8),
		.ss            (ss),
		.acsiPush      (acsiPush),
		.acsiPushData  (acsiPushData),
		.acsiFull      (acsiFull),
		.acsiOut       (acsiOut),
		.acsiOutStrobe (acsiOutStrobe)
	);

endmodule

`default_nettype wire

// File: src/acsiOutFifo.sv
// eight entry acsi output fifo popped on strobe rising edge
`timescale 1ns/1ps
`default_nettype none

module acsiOutFifo (
	input  wire clk_8,
	input  wire ss,
	input  wire acsiPush,
	input  wire stDataPkg::acsiWordT acsiPushData,
	output logic acsiFull,
	output stDataPkg::acsiOutS acsiOut,
	input  wire acsiOutStrobe // sck domain
);

	stDataPkg::acsiWordT mem [stDataPkg::acsiFifoDepth];
	logic [stDataPkg::acsiPtrW:0] wrPtr; // extra bit tells full from empty
	logic [stDataPkg::acsiPtrW:0] rdPtr;
	logic [2:0] strobeSync;
	logic empty;
	logic push;
	logic pop;

	assign empty    = (wrPtr == rdPtr);
	assign acsiFull = (wrPtr[stDataPkg::acsiPtrW] != rdPtr[stDataPkg::acsiPtrW])
		&& (wrPtr[stDataPkg::acsiPtrW-1:0] == rdPtr[stDataPkg::acsiPtrW-1:0]);
	assign push = acsiPush && !acsiFull;                   // full drops it
	assign pop  = strobeSync[1] && !strobeSync[2] && !empty; // empty stays empty
	assign acsiOut = '{available: !empty, data: mem[rdPtr[stDataPkg::acsiPtrW-1:0]]};

	always_ff @(posedge clk_8, posedge ss) begin
		if (ss) begin
			wrPtr      <= '0;
			rdPtr      <= '0;
			strobeSync <= '0;
		end else begin
			strobeSync <= {strobeSync[1:0], acsiOutStrobe};
			if (push)
				wrPtr <= wrPtr + (stDataPkg::acsiPtrW + 1)'(1);
			if (pop)
				rdPtr <= rdPtr + (stDataPkg::acsiPtrW + 1)'(1);
		end
	end

	always_ff @(posedge clk_8) begin
		if (push)
			mem[wrPtr[stDataPkg::acsiPtrW-1:0]] <= acsiPushData;
	end

endmodule

`default_nettype wire

// File: src/dmaStatus.sv
// 32 byte status register file with load port and ack clear of the busy byte
`timescale 1ns/1ps
`default_nettype none

module dmaStatus (
	input  wire clk_8,
	input  wire ss,
	// load port
	input  wire statusWe,
	input  wire stDataPkg::dmaIdxT statusIdx,
	input  wire stDataPkg::byteT statusData,
	// client side
	input  wire stDataPkg::dmaIdxT dmaIdx,
	output stDataPkg::byteT dmaData,
	input  wire dmaAck // sck domain pulse
);

	stDataPkg::byteT regs [32];
	logic [2:0] ackSync; // two flops plus edge history
	logic ackRise;

	assign ackRise = ackSync[1] && !ackSync[2];
	assign dmaData = regs[dmaIdx];

	always_ff @(posedge clk_8, posedge ss) begin
		if (ss) begin
			ackSync <= '0;
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else begin
			ackSync <= {ackSync[1:0], dmaAck};
			if (statusWe)
				regs[statusIdx] <= statusData;
			if (ackRise)
				regs[0] <= '0; // busy byte cleared even over a load
		end
	end

endmodule

`default_nettype wire

// File: src/ramHost.sv
// bus slot counter and behavioural word ram driven by ram state codes
`timescale 1ns/1ps
`default_nettype none

module ramHost (
	input  wire clk_8,
	input  wire ss,
	output stDataPkg::busCycleT busCycle,
	input  wire stDataPkg::ramReqS ramReq,
	output stDataPkg::wordT ramData,
	output logic ack
);

	stDataPkg::wordT mem [stDataPkg::ramWords];
	logic [stDataPkg::ramAddrW-1:0] wordAddr; // only the modelled depth
	logic doWrite;
	logic doRead;

	assign wordAddr = ramReq.addr[stDataPkg::ramAddrW-1:0];
	assign doWrite  = (ramReq.state == stDataPkg::ramWrite);
	assign doRead   = (ramReq.state == stDataPkg::ramRead);

	// four free running slots
	always_ff @(posedge clk_8, posedge ss) begin
		if (ss)
			busCycle <= '0;
		else
			busCycle <= busCycle + stDataPkg::busCycleT'(1);
	end

	// ack lands the cycle after the state code
	always_ff @(posedge clk_8, posedge ss) begin
		if (ss)
			ack <= 1'b0;
		else
			ack <= doWrite || doRead;
	end

	always_ff @(posedge clk_8) begin
		if (doWrite)
			mem[wordAddr] <= ramReq.wData;
		if (doRead)
			ramData <= mem[wordAddr]; // held until next read
	end

endmodule

`default_nettype wire

// File: src/spiDataClient.sv
// spi command decoder, payload shifter and ram request generator
`timescale 1ns/1ps
`default_nettype none

module spiDataClient (
	input  wire clk_8,
	input  wire ss,
	input  wire stDataPkg::busCycleT busCycle,
	// spi pins
	input  wire sdi,
	input  wire sck,
	input  wire spiSel, // high = idle
	output logic sdo,
	output stDataPkg::wordT ctrlOut,
	// dma status file
	output stDataPkg::dmaIdxT dmaIdx,
	input  wire stDataPkg::byteT dmaData,
	output logic dmaAck,
	// acsi output fifo
	input  wire stDataPkg::acsiOutS acsiOut,
	output logic acsiOutStrobe,
	// ram host
	output stDataPkg::ramReqS ramReq,
	input  wire stDataPkg::wordT ramData,
	input  wire ack
);

	logic [4:0] cnt;            // bit counter 0..7 for the command then 8..23 rolling
	stDataPkg::dmaIdxT bcnt;    // payload byte counter
	logic [14:0] sbuf;          // shift-in buffer
	stDataPkg::byteT cmd;
	stDataPkg::byteT rxByte;    // byte completing on this edge
	stDataPkg::addrT addrR;     // word address, pre-incremented
	stDataPkg::wordT wData;
	logic write;                // sck domain requests
	logic read;
	logic [1:0] writeSync;      // into clk_8
	logic [1:0] readSync;
	logic writeD;
	logic writeD2;
	logic readD;
	logic readD2;
	stDataPkg::ramStateE ramState;
	stDataPkg::wordT rdWord;    // last word returned by the host
	stDataPkg::wordT txData;    // shift-out register

	assign rxByte = {sbuf[6:0], sdi};
	assign dmaIdx = bcnt;
	assign sdo    = txData[15];

	// writes see an address already bumped at the word end
	assign ramReq = '{
		state: ramState,
		addr:  addrR - stDataPkg::addrT'(cmd == stDataPkg::cmdWriteRam),
		wData: wData
	};

	// request sync and one-cycle state codes
	always_ff @(posedge clk_8, posedge ss) begin
		if (ss) begin
			writeSync <= '0;
			readSync  <= '0;
			writeD    <= 1'b0;
			writeD2   <= 1'b0;
			readD     <= 1'b0;
			readD2    <= 1'b0;
			ramState  <= stDataPkg::ramInit;
		end else begin
			writeSync <= {writeSync[0], write};
			readSync  <= {readSync[0], read};
			// hold off until the slot before io has passed
			writeD  <= writeSync[1] && ((busCycle == stDataPkg::busCycleT'(3)) || writeD);
			writeD2 <= writeD;
			readD   <= readSync[1] && ((busCycle == stDataPkg::busCycleT'(3)) || readD);
			readD2  <= readD;
			if (writeD && !writeD2)
				ramState <= stDataPkg::ramWrite;
			else if (readD && !readD2)
				ramState <= stDataPkg::ramRead;
			else
				ramState <= stDataPkg::ramIdle;
		end
	end

	always_ff @(posedge clk_8) begin
		if (ack)
			rdWord <= ramData; // write acks just recapture the old word
	end

	// spi control side cleared by idle select
	always_ff @(posedge sck, posedge spiSel) begin
		if (spiSel) begin
			cnt    <= '0;
			bcnt   <= '0;
			write  <= 1'b0;
			read   <= 1'b0;
			dmaAck <= 1'b0;
		end else begin
			dmaAck <= 1'b0;
			cnt <= (cnt < 5'd23) ? cnt + 5'd1 : 5'd8;
			if ((cnt == 5'd15) || (cnt == 5'd23))
				bcnt <= bcnt + 5'd1;
			if (cnt == 5'd7) begin
				dmaAck <= (rxByte == stDataPkg::cmdDmaAck);
				if (rxByte == stDataPkg::cmdReadRam)
					read <= 1'b1; // first read asap
			end
			if ((cmd == stDataPkg::cmdWriteRam) && (cnt >= 5'd8)) begin
				if (cnt == 5'd16)
					write <= 1'b0;
				else if (cnt == 5'd23)
					write <= 1'b1;
			end
			if ((cmd == stDataPkg::cmdReadRam) && (cnt >= 5'd8)) begin
				if (cnt == 5'd16)
					read <= 1'b0;
				else if (cnt == 5'd23)
					read <= 1'b1; // prefetch next word
			end
		end
	end

	// spi payload side
	always_ff @(posedge sck) begin
		sbuf <= {sbuf[13:0], sdi};
		if (cnt == 5'd7)
			cmd <= rxByte;
		if (cnt >= 5'd8) begin
			if (cmd == stDataPkg::cmdSetAddr)
				addrR <= {addrR[21:0], sdi};
			if (((cmd == stDataPkg::cmdWriteRam) || (cmd == stDataPkg::cmdReadRam))
					&& (cnt == 5'd23))
				addrR <= addrR + stDataPkg::addrT'(1);
			if ((cmd == stDataPkg::cmdWriteRam) && (cnt == 5'd23))
				wData <= {sbuf, sdi};
			if ((cmd == stDataPkg::cmdSetCtrl) && (cnt == 5'd23))
				ctrlOut <= {sbuf, sdi};
		end
	end

	// falling edge shifter
	always_ff @(negedge sck) begin
		if (cmd == stDataPkg::cmdReadRam) begin
			if (cnt == 5'd8)
				txData <= rdWord;
			else
				txData <= {txData[14:0], 1'b0};
		end else if (cmd == stDataPkg::cmdReadDma) begin
			if ((cnt == 5'd8) || (cnt == 5'd16))
				txData[15:8] <= dmaData;
			else
				txData <= {txData[14:0], 1'b0};
		end else if (cmd == stDataPkg::cmdReadAcsi) begin
			if (cnt == 5'd8)
				txData[15:8] <= {5'd0, acsiOut.data[9:8], acsiOut.available}; // flag byte
			else if (cnt == 5'd16)
				txData[15:8] <= acsiOut.data[7:0];
			else
				txData <= {txData[14:0], 1'b0};
		end
	end

	// pop strobe rises with the data byte
	always_ff @(negedge sck, posedge spiSel) begin
		if (spiSel) begin
			acsiOutStrobe <= 1'b0;
		end else if (cmd == stDataPkg::cmdReadAcsi) begin
			if (cnt == 5'd8)
				acsiOutStrobe <= 1'b0;
			else if (cnt == 5'd16)
				acsiOutStrobe <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/stDataPkg.sv
// shared widths, vector types, spi command codes, ram state enum and bus structs
`default_nettype none

package stDataPkg;

	typedef logic [15:0] wordT;     // ram word / control word
	typedef logic [22:0] addrT;     // ram word address
	typedef logic [7:0]  byteT;     // status or spi payload byte
	typedef logic [9:0]  acsiWordT; // {addr[1:0], data[7:0]}
	typedef logic [4:0]  dmaIdxT;   // status byte index
	typedef logic [1:0]  busCycleT; // slot 3 comes right before the io slot

	// ram host command codes as seen on the sdram host state bits
	typedef enum logic [2:0] {
		ramInit  = 3'b101,
		ramIdle  = 3'b001,
		ramWrite = 3'b011,
		ramRead  = 3'b010
	} ramStateE;

	// first spi byte of a transfer
	localparam byteT cmdSetAddr  = 8'd1;
	localparam byteT cmdWriteRam = 8'd2;
	localparam byteT cmdReadRam  = 8'd3;
	localparam byteT cmdSetCtrl  = 8'd4;
	localparam byteT cmdReadDma  = 8'd5;
	localparam byteT cmdDmaAck   = 8'd6;
	localparam byteT cmdReadAcsi = 8'd7;

	localparam int ramWords      = 4096;             // modelled ram depth
	localparam int ramAddrW      = $clog2(ramWords); // upper address bits ignored
	localparam int acsiFifoDepth = 8;
	localparam int acsiPtrW      = $clog2(acsiFifoDepth);

	typedef struct packed {
		ramStateE state;
		addrT     addr;
		wordT     wData; // write data
	} ramReqS;

	typedef struct packed {
		logic     available; // fifo not empty
		acsiWordT data;      // head entry
	} acsiOutS;

endpackage

`default_nettype wire
